//--- vread.f
rtl/bus_pkg.sv
rtl/gen_pkg.sv
rtl/databus_if.sv
rtl/burst_fetch.sv
rtl/pattern_addr_gen.sv
rtl/pingpong_ram.sv
rtl/vread_unit.sv
rtl/databus_arbiter.sv
rtl/vread_top.sv
sim/tb_vread_top.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_vread_top -f vread.f \
   && ./obj_dir/Vtb_vread_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sim/tb_vread_top.sv
module tb_vread_top
   import bus_pkg::*, gen_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_ROWS = 4;
   localparam bus_data_t MEM_KEY = 32'h5a5a_0000;

   typedef struct {
      logic         run;
      logic         pp;
      logic         en;
      bus_addr_t    addr;
      len_t         len;
      pattern_cfg_t cfg;
      int           count;
   } unit_step_t;

   logic        clk;
   logic        rst;
   logic [1:0]  run;
   logic [1:0]  pingpong;
   logic [1:0]  enable;
   bus_addr_t   ext_addr [2];
   len_t        len [2];
   local_addr_t start [2];
   local_addr_t incr [2];
   period_t     per [2];
   period_t     duty [2];
   local_addr_t iter [2];
   local_addr_t shift [2];
   logic [1:0]  out_valid;
   out_word_t   out_data [2];
   logic [1:0]  done;
   logic        bus_req_valid;
   bus_addr_t   bus_addr;
   len_t        bus_len;
   logic        bus_req_ready;
   logic        bus_beat_ready;
   bus_data_t   bus_rdata;
   logic        bus_last;

   unit_step_t  steps [N_ROWS][2];
   // expected output per cycle or -1 for a gap
   int          slots [2][$];
   int          skip [2];
   int          seen [2];
   logic        pp_model [2];
   bus_addr_t   half_base [2][2];
   logic        mem_busy;
   bus_addr_t   mem_addr;
   len_t        mem_left;
   logic [31:0] rng;
   int          cycles;
   int          limit;

   vread_top #(
      .N_UNITS (2)
   ) vread_top_i (
      .clk              (clk),
      .rst              (rst),
      .run_i            (run),
      .pingpong_i       (pingpong),
      .enable_i         (enable),
      .ext_addr_i       (ext_addr),
      .len_i            (len),
      .start_i          (start),
      .incr_i           (incr),
      .per_i            (per),
      .duty_i           (duty),
      .iter_i           (iter),
      .shift_i          (shift),
      .out_valid_o      (out_valid),
      .out_data_o       (out_data),
      .done_o           (done),
      .bus_req_valid_o  (bus_req_valid),
      .bus_addr_o       (bus_addr),
      .bus_len_o        (bus_len),
      .bus_req_ready_i  (bus_req_ready),
      .bus_beat_ready_i (bus_beat_ready),
      .bus_rdata_i      (bus_rdata),
      .bus_last_i       (bus_last)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_word(input int u, input out_word_t got, input out_word_t exp);
      if (got !== exp) begin
         stop_run($sformatf("ERROR @%0t: unit %0d output %h, expected %h", $time, u, got, exp));
      end
   endtask

   task automatic check_valid(input int u, input logic got, input logic exp);
      if (got !== exp) begin
         stop_run($sformatf("ERROR @%0t: unit %0d valid %b, expected %b", $time, u, got, exp));
      end
   endtask

   task automatic check_req(input logic got, input logic exp);
      if (got !== exp) begin
         stop_run($sformatf("ERROR @%0t: bus request valid %b, expected %b",
                            $time, got, exp));
      end
   endtask

   task automatic check_done(input logic [1:0] got, input logic [1:0] exp);
      if (got !== exp) begin
         stop_run($sformatf("ERROR @%0t: done %b, expected %b", $time, got, exp));
      end
   endtask

   task automatic check_count(input int u, input int got, input int exp);
      if (got != exp) begin
         stop_run($sformatf("ERROR @%0t: unit %0d gave %0d words, expected %0d",
                            $time, u, got, exp));
      end
   endtask

   // memory model serves one burst at a time with random beat stalls
   task automatic serve_bus();
      logic go;
      if (!mem_busy) begin
         bus_req_ready  = 1'b1;
         bus_beat_ready = 1'b0;
         bus_last       = 1'b0;
         if (bus_req_valid) begin
            mem_busy = 1'b1;
            mem_addr = bus_addr;
            mem_left = bus_len;
         end
      end else begin
         rng = xorshift(rng);
         go  = (rng % 10) < 7;
         bus_req_ready  = 1'b0;
         bus_beat_ready = go;
         bus_rdata      = mem_addr ^ MEM_KEY;
         bus_last       = go && (mem_left == len_t'(1));
         if (go) begin
            mem_addr = mem_addr + 32'd4;
            mem_left = mem_left - len_t'(1);
            mem_busy = (mem_left != '0);
         end
      end
   endtask

   task automatic watch_output(input int u);
      int exp;
      if (skip[u] > 0) begin
         skip[u]--;
      end else if (slots[u].size() > 0) begin
         exp = slots[u].pop_front();
         check_valid(u, out_valid[u], exp >= 0);
         if (exp >= 0) begin
            check_word(u, out_data[u], out_word_t'(exp));
            seen[u]++;
         end
      end else begin
         check_valid(u, out_valid[u], 1'b0);
      end
   endtask

   task automatic step_clock();
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
         stop_run($sformatf("timeout: the DUT did not finish within %0d cycles", limit));
      end
      serve_bus();
      for (int u = 0; u < 2; u++) begin
         watch_output(u);
      end
   endtask

   // duty slots emit and step by incr and every period adds shift
   task automatic build_slots(input int u, input unit_step_t s, input logic rd_pp);
      local_addr_t a;
      logic        h;
      bus_data_t   word;
      a = s.cfg.start;
      slots[u].delete();
      for (int i = 0; i < int'(s.cfg.iter); i++) begin
         for (int p = 0; p < int'(s.cfg.per); p++) begin
            if (p < int'(s.cfg.duty)) begin
               h    = s.pp ? rd_pp : a[ADDR_W-1];
               word = (half_base[u][h] + 32'(a[ADDR_W-2:1]) * 4) ^ MEM_KEY;
               slots[u].push_back(a[0] ? int'(word[31:16]) : int'(word[15:0]));
               a = a + s.cfg.incr;
            end else begin
               slots[u].push_back(-1);
            end
         end
         a = a + s.cfg.shift;
      end
      // the last period ends at its last enabled slot
      while (slots[u].size() > 0 && slots[u][$] == -1) begin
         void'(slots[u].pop_back());
      end
   endtask

   task automatic run_row(input int r);
      logic [1:0] runs;
      logic       new_pp;
      unit_step_t s;
      runs = '0;
      step_clock();
      for (int u = 0; u < 2; u++) begin
         s           = steps[r][u];
         pingpong[u] = s.pp;
         enable[u]   = s.en;
         ext_addr[u] = s.addr;
         len[u]      = s.len;
         start[u]    = s.cfg.start;
         incr[u]     = s.cfg.incr;
         per[u]      = s.cfg.per;
         duty[u]     = s.cfg.duty;
         iter[u]     = s.cfg.iter;
         shift[u]    = s.cfg.shift;
         seen[u]     = 0;
         if (s.run) begin
            new_pp = s.pp ? !pp_model[u] : 1'b0;
            build_slots(u, s, new_pp);
            if (s.en && s.len != '0) begin
               half_base[u][s.pp ? !new_pp : 1'b0] = s.addr;
            end
            pp_model[u] = new_pp;
            skip[u]     = 1;
            runs[u]     = 1'b1;
         end
      end
      run = runs;
      step_clock();
      run = '0;
      check_done(done, ~runs);
      while (done != 2'b11) begin
         step_clock();
      end
      for (int u = 0; u < 2; u++) begin
         check_count(u, seen[u], steps[r][u].count);
      end
   endtask

   // run, pingpong, enable, fetch address, length,
   // {start, incr, per, duty, iter, shift}, output words
   task automatic load_table();
      steps[0][0] = '{1'b1, 1'b1, 1'b1, 32'h0000_1000, 16'd16,
                      '{10'd0, 10'd1, 8'd1, 8'd1, 10'd0, 10'd0}, 0};
      steps[0][1] = '{1'b1, 1'b1, 1'b1, 32'h0000_8000, 16'd24,
                      '{10'd0, 10'd1, 8'd1, 8'd1, 10'd0, 10'd0}, 0};
      steps[1][0] = '{1'b1, 1'b1, 1'b1, 32'h0000_2000, 16'd12,
                      '{10'd0, 10'd1, 8'd32, 8'd32, 10'd1, 10'd0}, 32};
      steps[1][1] = '{1'b1, 1'b1, 1'b1, 32'h0000_9000, 16'd20,
                      '{10'd1, 10'd1, 8'd6, 8'd4, 10'd5, 10'd2}, 20};
      steps[2][0] = '{1'b1, 1'b1, 1'b0, 32'h0000_3000, 16'd8,
                      '{10'd0, 10'd2, 8'd4, 8'd2, 10'd3, 10'd1}, 6};
      steps[2][1] = '{1'b1, 1'b1, 1'b1, 32'h0000_a000, 16'd0,
                      '{10'd2, 10'd3, 8'd3, 8'd3, 10'd4, 10'd0}, 12};
      steps[3][0] = '{1'b1, 1'b1, 1'b1, 32'h0000_5000, 16'd16,
                      '{10'd31, 10'h3ff, 8'd2, 8'd1, 10'd8, 10'd0}, 8};
      steps[3][1] = '{1'b1, 1'b0, 1'b1, 32'h0000_b000, 16'd10,
                      '{10'h200, 10'd1, 8'd5, 8'd5, 10'd2, 10'd0}, 10};
   endtask

   initial begin
      rng        = 32'had24_8886;
      cycles     = 0;
      mem_busy   = 1'b0;
      mem_addr   = '0;
      mem_left   = '0;
      run        = '0;
      pingpong   = '0;
      enable     = '0;
      for (int u = 0; u < 2; u++) begin
         ext_addr[u]     = '0;
         len[u]          = '0;
         start[u]        = '0;
         incr[u]         = '0;
         per[u]          = '0;
         duty[u]         = '0;
         iter[u]         = '0;
         shift[u]        = '0;
         skip[u]         = 0;
         seen[u]         = 0;
         pp_model[u]     = 1'b0;
         half_base[u][0] = '0;
         half_base[u][1] = '0;
      end
      bus_req_ready  = 1'b0;
      bus_beat_ready = 1'b0;
      bus_rdata      = '0;
      bus_last       = 1'b0;
      load_table();
      limit = 200;
      for (int r = 0; r < N_ROWS; r++) begin
         limit += (steps[r][0].count + steps[r][1].count + int'(steps[r][0].len) +
                   int'(steps[r][1].len)) * 8;
      end
      rst = 1'b1;
      repeat (10) step_clock();
      rst = 1'b0;
      check_done(done, 2'b11);
      check_req(bus_req_valid, 1'b0);
      for (int r = 0; r < N_ROWS; r++) begin
         run_row(r);
      end
      $display("all tests passed");
      $finish;
   end

endmodule

//--- rtl/vread_top.sv
module vread_top
   import bus_pkg::*, gen_pkg::*;
#(
   parameter int N_UNITS = 2
) (
   input  logic               clk,
   input  logic               rst,
   // per-unit run and fetch setup
   input  logic [N_UNITS-1:0] run_i,
   input  logic [N_UNITS-1:0] pingpong_i,
   input  logic [N_UNITS-1:0] enable_i,
   input  bus_addr_t          ext_addr_i [N_UNITS],
   input  len_t               len_i      [N_UNITS],
   // per-unit output pattern
   input  local_addr_t        start_i    [N_UNITS],
   input  local_addr_t        incr_i     [N_UNITS],
   input  period_t            per_i      [N_UNITS],
   input  period_t            duty_i     [N_UNITS],
   input  local_addr_t        iter_i     [N_UNITS],
   input  local_addr_t        shift_i    [N_UNITS],
   output logic [N_UNITS-1:0] out_valid_o,
   output out_word_t          out_data_o [N_UNITS],
   output logic [N_UNITS-1:0] done_o,
   // shared external data bus
   output logic               bus_req_valid_o,
   output bus_addr_t          bus_addr_o,
   output len_t               bus_len_o,
   input  logic               bus_req_ready_i,
   input  logic               bus_beat_ready_i,
   input  bus_data_t          bus_rdata_i,
   input  logic               bus_last_i
);

   databus_if unit_bus [N_UNITS] ();

   for (genvar u = 0; u < N_UNITS; u++) begin : g_unit
      pattern_cfg_t cfg;

      assign cfg = '{start: start_i[u], incr: incr_i[u], per: per_i[u],
                     duty: duty_i[u], iter: iter_i[u], shift: shift_i[u]};

      vread_unit vread_unit_i (
         .clk         (clk),
         .rst         (rst),
         .run_i       (run_i[u]),
         .pingpong_i  (pingpong_i[u]),
         .enable_i    (enable_i[u]),
         .ext_addr_i  (ext_addr_i[u]),
         .len_i       (len_i[u]),
         .cfg_i       (cfg),
         .bus         (unit_bus[u]),
         .out_valid_o (out_valid_o[u]),
         .out_data_o  (out_data_o[u]),
         .done_o      (done_o[u])
      );
   end

   databus_arbiter #(
      .N_UNITS (N_UNITS)
   ) databus_arbiter_i (
      .clk              (clk),
      .rst              (rst),
      .masters          (unit_bus),
      .bus_req_valid_o  (bus_req_valid_o),
      .bus_addr_o       (bus_addr_o),
      .bus_len_o        (bus_len_o),
      .bus_req_ready_i  (bus_req_ready_i),
      .bus_beat_ready_i (bus_beat_ready_i),
      .bus_rdata_i      (bus_rdata_i),
      .bus_last_i       (bus_last_i)
   );

endmodule

//--- rtl/databus_arbiter.sv
module databus_arbiter
   import bus_pkg::*;
#(
   parameter int N_UNITS = 2
) (
   input  logic       clk,
   input  logic       rst,
   databus_if.arbiter masters [N_UNITS],
   output logic       bus_req_valid_o,
   output bus_addr_t  bus_addr_o,
   output len_t       bus_len_o,
   input  logic       bus_req_ready_i,
   input  logic       bus_beat_ready_i,
   input  bus_data_t  bus_rdata_i,
   input  logic       bus_last_i
);

   localparam int IDX_W = (N_UNITS > 1) ? $clog2(N_UNITS) : 1;

   logic [N_UNITS-1:0] req_vec;
   bus_addr_t          addr_arr [N_UNITS];
   len_t               len_arr  [N_UNITS];
   logic               busy;
   logic [IDX_W-1:0]   grant_q;
   logic [IDX_W-1:0]   ptr;
   logic [IDX_W-1:0]   sel_idx;
   logic               sel_found;
   logic               accept;
   logic               burst_end;

   for (genvar i = 0; i < N_UNITS; i++) begin : g_master
      assign req_vec[i]  = masters[i].req_valid;
      assign addr_arr[i] = masters[i].addr;
      assign len_arr[i]  = masters[i].len;
      assign masters[i].req_ready  = !busy && sel_found && (sel_idx == IDX_W'(i)) &&
                                     bus_req_ready_i;
      assign masters[i].beat_ready = busy && (grant_q == IDX_W'(i)) && bus_beat_ready_i;
      assign masters[i].last       = busy && (grant_q == IDX_W'(i)) && bus_last_i;
      assign masters[i].rdata      = bus_rdata_i;
   end

   // first requester at or after the pointer
   always_comb begin
      int cand;
      sel_found = 1'b0;
      sel_idx   = '0;
      for (int k = N_UNITS - 1; k >= 0; k--) begin
         cand = (int'(ptr) + k) % N_UNITS;
         if (req_vec[cand]) begin
            sel_found = 1'b1;
            sel_idx   = IDX_W'(cand);
         end
      end
   end

   assign bus_req_valid_o = !busy && sel_found;
   assign bus_addr_o      = addr_arr[sel_idx];
   assign bus_len_o       = len_arr[sel_idx];
   assign accept          = bus_req_valid_o && bus_req_ready_i;
   assign burst_end       = busy && bus_beat_ready_i && bus_last_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy    <= 1'b0;
         grant_q <= '0;
         ptr     <= '0;
      end else if (accept) begin
         busy    <= 1'b1;
         grant_q <= sel_idx;
      end else if (burst_end) begin
         busy <= 1'b0;
         ptr  <= (grant_q == IDX_W'(N_UNITS - 1)) ? '0 : grant_q + IDX_W'(1);
      end
   end

   // beats only arrive inside a granted burst
   a_beat_in_burst: assert property (@(posedge clk) disable iff (rst)
      bus_beat_ready_i |-> busy)
      else $error("data beat outside a granted burst");

endmodule

//--- rtl/vread_unit.sv
module vread_unit
   import bus_pkg::*, gen_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  logic         run_i,
   input  logic         pingpong_i,
   input  logic         enable_i,
   input  bus_addr_t    ext_addr_i,
   input  len_t         len_i,
   input  pattern_cfg_t cfg_i,
   databus_if.master    bus,
   output logic         out_valid_o,
   output out_word_t    out_data_o,
   output logic         done_o
);

   logic        pp_state;
   logic        fill_half;
   logic        rd_half;
   logic        fetch_done;
   logic        pat_done;
   logic        wr_en;
   local_addr_t wr_addr;
   bus_data_t   wr_data;
   logic        rd_en;
   local_addr_t rd_addr;
   local_addr_t ram_rd_addr;
   bus_data_t   rd_data;
   logic        hw_sel;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_state <= 1'b0;
      end else if (run_i) begin
         pp_state <= pingpong_i ? !pp_state : 1'b0;
      end
   end

   // without ping-pong, fetch fills half 0 and the pattern msb picks the half
   assign fill_half = pingpong_i ? !pp_state : 1'b0;
   assign rd_half   = pingpong_i ? pp_state : rd_addr[ADDR_W-1];

   // pattern counts halfwords, bit 0 picks the halfword
   assign ram_rd_addr = {rd_half, 1'b0, rd_addr[ADDR_W-2:1]};

   burst_fetch burst_fetch_i (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .enable_i    (enable_i),
      .ext_addr_i  (ext_addr_i),
      .len_i       (len_i),
      .fill_half_i (fill_half),
      .bus         (bus),
      .wr_en_o     (wr_en),
      .wr_addr_o   (wr_addr),
      .wr_data_o   (wr_data),
      .done_o      (fetch_done)
   );

   pattern_addr_gen pattern_addr_gen_i (
      .clk       (clk),
      .rst       (rst),
      .run_i     (run_i),
      .cfg_i     (cfg_i),
      .rd_en_o   (rd_en),
      .rd_addr_o (rd_addr),
      .done_o    (pat_done)
   );

   pingpong_ram pingpong_ram_i (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_addr_i (ram_rd_addr),
      .rd_data_o (rd_data)
   );

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid_o <= 1'b0;
         done_o      <= 1'b1;
      end else begin
         out_valid_o <= rd_en;
         if (run_i) begin
            done_o <= 1'b0;
         end else if (fetch_done && pat_done) begin
            done_o <= 1'b1;
         end
      end
   end

   // halfword select travels with the RAM read
   always_ff @(posedge clk) begin
      if (rd_en) begin
         hw_sel <= rd_addr[0];
      end
   end

   assign out_data_o = hw_sel ? rd_data[BUS_DATA_W-1:OUT_W] : rd_data[OUT_W-1:0];

   // the half bit of start is overridden under ping-pong
   a_start_half: assert property (@(posedge clk) disable iff (rst)
      run_i && pingpong_i |-> !cfg_i.start[ADDR_W-1])
      else $error("pattern start sets the half bit with ping-pong on");

endmodule

//--- rtl/pingpong_ram.sv
module pingpong_ram
   import bus_pkg::*, gen_pkg::*;
(
   input  logic        clk,
   input  logic        wr_en_i,
   input  local_addr_t wr_addr_i,
   input  bus_data_t   wr_data_i,
   input  logic        rd_en_i,
   input  local_addr_t rd_addr_i,
   output bus_data_t   rd_data_o
);

   bus_data_t mem [2**ADDR_W];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // read data one cycle after the enable
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

//--- rtl/pattern_addr_gen.sv
module pattern_addr_gen
   import gen_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  logic         run_i,
   input  pattern_cfg_t cfg_i,
   output logic         rd_en_o,
   output local_addr_t  rd_addr_o,
   output logic         done_o
);

   logic        active;
   logic        empty_cfg;
   period_t     per_cnt;
   local_addr_t iter_cnt;
   local_addr_t addr;
   period_t     end_pos;
   logic        en;
   logic        wrap;
   logic        last_iter;

   assign empty_cfg = (cfg_i.per == '0) || (cfg_i.iter == '0);

   // final period stops after its last enabled slot
   assign end_pos = (cfg_i.duty != '0 && cfg_i.duty < cfg_i.per) ?
                    cfg_i.duty - period_t'(1) : cfg_i.per - period_t'(1);

   assign en        = active && (per_cnt < cfg_i.duty);
   assign wrap      = (per_cnt == cfg_i.per - period_t'(1));
   assign last_iter = (iter_cnt == cfg_i.iter - local_addr_t'(1));

   assign rd_en_o   = en;
   assign rd_addr_o = addr;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active   <= 1'b0;
         done_o   <= 1'b1;
         per_cnt  <= '0;
         iter_cnt <= '0;
      end else if (run_i) begin
         active   <= !empty_cfg;
         done_o   <= empty_cfg;
         per_cnt  <= '0;
         iter_cnt <= '0;
      end else if (active) begin
         if (last_iter && per_cnt == end_pos) begin
            active <= 1'b0;
            done_o <= 1'b1;
         end
         if (wrap) begin
            per_cnt  <= '0;
            iter_cnt <= iter_cnt + local_addr_t'(1);
         end else begin
            per_cnt <= per_cnt + period_t'(1);
         end
      end
   end

   // incr per enabled slot, shift per period boundary
   always_ff @(posedge clk) begin
      if (run_i) begin
         addr <= cfg_i.start;
      end else if (active) begin
         addr <= addr + (en ? cfg_i.incr : '0) + (wrap ? cfg_i.shift : '0);
      end
   end

endmodule

//--- rtl/burst_fetch.sv
module burst_fetch
   import bus_pkg::*, gen_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        run_i,
   input  logic        enable_i,
   input  bus_addr_t   ext_addr_i,
   input  len_t        len_i,
   input  logic        fill_half_i,
   databus_if.master   bus,
   output logic        wr_en_o,
   output local_addr_t wr_addr_o,
   output bus_data_t   wr_data_o,
   output logic        done_o
);

   logic        start;
   logic        req_valid;
   bus_addr_t   addr_q;
   len_t        len_q;
   // write address stream
   logic        gen_valid;
   logic        gen_ready;
   local_addr_t gen_cnt;
   // beat stream
   logic        beat_valid;
   logic        beat_end;

   // empty or disabled runs never touch the bus
   assign start = run_i && enable_i && (len_i != '0);

   assign bus.req_valid = req_valid;
   assign bus.addr      = addr_q;
   assign bus.len       = len_q;

   // join of address and beat streams
   assign beat_valid = bus.beat_ready;
   assign gen_ready  = beat_valid;
   assign beat_end   = beat_valid && bus.last;

   assign wr_en_o   = gen_valid && beat_valid;
   assign wr_addr_o = {fill_half_i, gen_cnt[ADDR_W-2:0]};
   assign wr_data_o = bus.rdata;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         req_valid <= 1'b0;
         gen_valid <= 1'b0;
         gen_cnt   <= '0;
         done_o    <= 1'b1;
      end else if (start) begin
         req_valid <= 1'b1;
         gen_valid <= 1'b1;
         gen_cnt   <= '0;
         done_o    <= 1'b0;
      end else begin
         if (req_valid && bus.req_ready) begin
            req_valid <= 1'b0;
         end
         if (gen_valid && gen_ready) begin
            gen_cnt <= gen_cnt + local_addr_t'(1);
         end
         if (gen_valid && beat_end) begin
            gen_valid <= 1'b0;
            done_o    <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         addr_q <= ext_addr_i;
         len_q  <= len_i;
      end
   end

   // a burst longer than one half would spill into the other half
   a_fill_in_half: assert property (@(posedge clk) disable iff (rst)
      wr_en_o |-> !gen_cnt[ADDR_W-1])
      else $error("burst overflows the ping-pong half");

endmodule

//--- rtl/databus_if.sv
interface databus_if
   import bus_pkg::*;
();

   logic      req_valid;
   logic      req_ready;
   bus_addr_t addr;
   len_t      len;
   // beats of the accepted burst
   logic      beat_ready;
   bus_data_t rdata;
   logic      last;

   modport master (
      output req_valid, addr, len,
      input  req_ready, beat_ready, rdata, last
   );

   modport arbiter (
      input  req_valid, addr, len,
      output req_ready, beat_ready, rdata, last
   );

endinterface

//--- rtl/gen_pkg.sv
package gen_pkg;

   // local RAM word address, msb picks the ping-pong half
   localparam int ADDR_W   = 10;
   localparam int PERIOD_W = 8;
   localparam int OUT_W    = 16;

   typedef logic [ADDR_W-1:0]   local_addr_t;
   typedef logic [PERIOD_W-1:0] period_t;
   typedef logic [OUT_W-1:0]    out_word_t;

   // output pattern, inner period/duty loop inside iter periods
   typedef struct packed {
      local_addr_t start;
      local_addr_t incr;
      period_t     per;
      period_t     duty;
      local_addr_t iter;
      local_addr_t shift;
   } pattern_cfg_t;

endpackage

//--- rtl/bus_pkg.sv
package bus_pkg;

   // external data bus, byte addressed
   localparam int BUS_ADDR_W = 32;
   localparam int BUS_DATA_W = 32;

   // burst length in bus words
   localparam int LEN_W = 16;

   typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
   typedef logic [BUS_DATA_W-1:0] bus_data_t;
   typedef logic [LEN_W-1:0]      len_t;

endpackage
